//--- project.f
source/i2c_proto_pkg.sv
source/apb_i2c_regmap_pkg.sv
source/i2c_clk_div.sv
source/i2c_shift_reg.sv
source/i2c_bit_seq.sv
source/i2c_byte_ctrl.sv
source/apb_i2c_regs.sv
source/apb_i2c_master.sv
verification/i2c_slave_model.sv
verification/tb_apb_i2c.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_apb_i2c
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -Wno-fatal

FILELIST := project.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) $(VFLAGS)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_apb_i2c.sv
`timescale 1ns/10ps
`default_nettype none

module tb_apb_i2c;

	import apb_i2c_regmap_pkg::*;

	localparam int N_TAB    = 5;
	localparam int WAIT_MAX = 4000; // clocks per wait

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        scl_oen;
	logic        sda_oen;
	logic        irq;
	logic        scl_line;
	logic        sda_line;
	logic [7:0]  slave_byte;
	logic        slave_mack;

	int          err_cnt;
	int          test_cnt;
	int          test_fail;
	int          err_start;
	integer      seed;
	integer      rnd;
	logic [31:0] rd_val;
	logic        lines_low;

	// stimulus table with -1 where a field is not checked
	string       tab_name [N_TAB];
	logic [7:0]  tab_cr   [N_TAB];
	logic [7:0]  tab_txr  [N_TAB];
	int          tab_rxack[N_TAB];
	int          tab_rxr  [N_TAB];
	int          tab_slv  [N_TAB];
	int          tab_mack [N_TAB];

	apb_i2c_master u_dut
	(
		.clk       (clk),
		.rst       (rst),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.scl_i     (scl_line),
		.sda_i     (sda_line),
		.pready_o  (pready),
		.prdata_o  (prdata),
		.scl_oen_o (scl_oen),
		.sda_oen_o (sda_oen),
		.i2c_irq_o (irq)
	);

	i2c_slave_model u_slave
	(
		.scl_oen_i    (scl_oen),
		.sda_oen_i    (sda_oen),
		.scl_o        (scl_line),
		.sda_o        (sda_line),
		.byte_o       (slave_byte),
		.master_ack_o (slave_mack)
	);

	initial
		clk = 1'b0;
	always #5 clk = ~clk;

	////////////////////
	// apb access
	////////////////////
	task automatic apb_write(input reg_addr_t a, input logic [7:0] d);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		pwrite  = 1'b1;
		paddr   = {24'h0, a, 2'b00};
		pwdata  = {24'h0, d};
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(posedge clk); // write lands here
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input reg_addr_t a, output logic [31:0] d);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		pwrite  = 1'b0;
		paddr   = {24'h0, a, 2'b00};
		@(posedge clk);
		#1;
		penable = 1'b1;
		#4;
		d = prdata; // sampled mid cycle when the comb read path has settled
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic set_entry
	(
		input int         i,
		input string      name,
		input logic [7:0] cr,
		input logic [7:0] txr,
		input int         rxack,
		input int         rxr,
		input int         slv,
		input int         mack
	);
		tab_name[i]  = name;
		tab_cr[i]    = cr;
		tab_txr[i]   = txr;
		tab_rxack[i] = rxack;
		tab_rxr[i]   = rxr;
		tab_slv[i]   = slv;
		tab_mack[i]  = mack;
	endtask

	////////////////////
	// bounded waits
	////////////////////
	task automatic wait_irq();
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_MAX)
		begin
			@(posedge clk);
			#2;
			seen = irq;
			n++;
		end
		if (!seen)
		begin
			$display("timeout: interrupt did not rise at time %0t", $time);
			err_cnt++;
		end
	endtask

	task automatic wait_tip_clear();
		int          n;
		logic        clear;
		logic [31:0] sr;
		n     = 0;
		clear = 1'b0;
		while (!clear && n < WAIT_MAX / 3)
		begin
			apb_read(ADDR_SR, sr);
			clear = ~sr[SR_TIP];
			n++;
		end
		if (!clear)
		begin
			$display("timeout: transfer in progress never cleared at time %0t", $time);
			err_cnt++;
		end
	endtask

	task automatic begin_test();
		test_cnt++;
		err_start = err_cnt;
	endtask

	task automatic end_test(input string name);
		if (err_cnt == err_start)
			$display("test %0d %s: ok", test_cnt, name);
		else
		begin
			$display("test %0d %s: FAILED", test_cnt, name);
			test_fail++;
		end
	endtask

	initial
	begin
		rst       = 1'b1;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		err_cnt   = 0;
		test_cnt  = 0;
		test_fail = 0;
		seed      = 15;
		rnd       = $random(seed);

		// cr, txr, rxack, rxr, slave byte, master ack
		set_entry(0, "address write", 8'h90, 8'hA0, 0, -1, 'hA0, -1);
		set_entry(1, "random data write", 8'h10, rnd[7:0], 0, -1, rnd[7:0], -1);
		set_entry(2, "nack on 0x51", 8'h90, 8'hA2, 1, -1, 'hA2, -1);
		set_entry(3, "address for read", 8'h90, 8'hA1, 0, -1, 'hA1, -1);
		set_entry(4, "read with nack and stop", 8'h68, 8'h00, 1, 'hA5, -1, 1);

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		////////////////////
		// reset and read back
		////////////////////
		begin_test();
		check("pready", pready, 1);
		apb_read(ADDR_PRER_LO, rd_val);
		check("PRER_LO", rd_val, 32'hFF);
		apb_read(ADDR_PRER_HI, rd_val);
		check("PRER_HI", rd_val, 32'hFF);
		apb_read(ADDR_CTR, rd_val);
		check("CTR", rd_val, 0);
		apb_read(ADDR_TXR, rd_val);
		check("TXR", rd_val, 0);
		apb_read(ADDR_RXR, rd_val);
		check("RXR", rd_val, 0);
		apb_read(ADDR_SR, rd_val);
		check("SR", rd_val, 0);
		apb_read(ADDR_CR, rd_val);
		check("CR", rd_val, 0);
		apb_write(ADDR_PRER_LO, 8'h04); // short runs
		apb_write(ADDR_PRER_HI, 8'h00);
		apb_write(ADDR_CTR, 8'hC0);     // en and ien
		apb_write(ADDR_TXR, 8'h5A);
		apb_read(ADDR_PRER_LO, rd_val);
		check("PRER_LO", rd_val, 32'h04);
		apb_read(ADDR_PRER_HI, rd_val);
		check("PRER_HI", rd_val, 32'h00);
		apb_read(ADDR_CTR, rd_val);
		check("CTR", rd_val, 32'hC0);
		apb_read(ADDR_TXR, rd_val);
		check("TXR", rd_val, 32'h5A);
		end_test("reset and read back");

		// table driven transfers with irq enabled
		for (int i = 0; i < N_TAB; i++)
		begin
			begin_test();
			apb_write(ADDR_TXR, tab_txr[i]);
			apb_write(ADDR_CR, tab_cr[i]);
			wait_irq();
			apb_read(ADDR_SR, rd_val);
			check("SR.TIP", rd_val[SR_TIP], 0);
			check("SR.IF", rd_val[SR_IF], 1);
			check("SR.RXACK", rd_val[SR_RXACK], tab_rxack[i]);
			apb_read(ADDR_CR, rd_val);
			check("CR command bits", rd_val & 32'hF0, 0); // cleared on done
			if (tab_rxr[i] >= 0)
			begin
				apb_read(ADDR_RXR, rd_val);
				check("RXR", rd_val, tab_rxr[i]);
			end
			if (tab_slv[i] >= 0)
				check("slave byte", slave_byte, tab_slv[i]);
			if (tab_mack[i] >= 0)
				check("master ack", slave_mack, tab_mack[i]);
			if (tab_cr[i][CR_STO])
			begin
				check("scl line", scl_line, 1);
				check("sda line", sda_line, 1);
			end
			check("irq before iack", irq, 1);
			apb_write(ADDR_CR, 8'h01);
			repeat (2) @(posedge clk);
			#2;
			check("irq after iack", irq, 0);
			apb_read(ADDR_SR, rd_val);
			check("SR.IF after iack", rd_val[SR_IF], 0);
			end_test(tab_name[i]);
		end

		////////////////////
		// flag without ien
		////////////////////
		begin_test();
		apb_write(ADDR_CTR, 8'h80);
		apb_write(ADDR_TXR, 8'hA0);
		apb_write(ADDR_CR, 8'hD0); // sta, sto, wr
		wait_tip_clear();
		repeat (3) @(posedge clk);
		apb_read(ADDR_SR, rd_val);
		check("SR.IF", rd_val[SR_IF], 1);
		check("irq pin", irq, 0);
		check("slave byte", slave_byte, 8'hA0);
		apb_write(ADDR_CR, 8'h01);
		apb_read(ADDR_SR, rd_val);
		check("SR.IF after iack", rd_val[SR_IF], 0);
		end_test("irq flag with ien clear");

		////////////////////
		// core disabled
		////////////////////
		begin_test();
		apb_write(ADDR_CTR, 8'h00);
		apb_write(ADDR_CR, 8'h90);
		apb_read(ADDR_CR, rd_val);
		check("CR", rd_val, 0);
		apb_read(ADDR_SR, rd_val);
		check("SR.TIP", rd_val[SR_TIP], 0); // a started byte would still be running
		lines_low = 1'b0;
		repeat (300)
		begin
			@(posedge clk);
			#2;
			if (!scl_line || !sda_line)
				lines_low = 1'b1;
		end
		check("lines pulled", lines_low, 0);
		end_test("core disable");

		$display("tests %0d, failed %0d, check errors %0d", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/i2c_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model
(
	input  wire logic  scl_oen_i,    // from the master
	input  wire logic  sda_oen_i,
	output logic       scl_o,        // resolved bus lines
	output logic       sda_o,
	output logic [7:0] byte_o,       // last byte shifted in
	output logic       master_ack_o  // ack level sent by the master on a read
);

	localparam logic [6:0] SLAVE_ADDR = 7'h50;
	localparam logic [7:0] READ_BYTE  = 8'hA5;

	logic       sda_pull; // 1 pulls sda low
	logic       scl_prev;
	logic       sda_prev;
	logic       active;     // between start and stop, addressed
	logic       addr_phase; // next byte is the address
	logic       reading;
	logic       ack_slot;   // we drive the ack bit
	logic       mack_slot;  // master drives the ack bit
	logic [7:0] rx_sh;
	logic [7:0] tx_sh;
	int         bit_cnt;

	// wired and, scl is never stretched
	assign scl_o = scl_oen_i;
	assign sda_o = sda_oen_i & ~sda_pull;

	initial
	begin
		sda_pull     = 1'b0;
		active       = 1'b0;
		addr_phase   = 1'b0;
		reading      = 1'b0;
		ack_slot     = 1'b0;
		mack_slot    = 1'b0;
		bit_cnt      = 0;
		byte_o       = 8'h00;
		master_ack_o = 1'b0;
	end

	always @(scl_o or sda_o)
	begin
		if (scl_o !== scl_prev)
		begin
			if (scl_o === 1'b1 && active)
			begin
				if (mack_slot)
					master_ack_o = sda_o;
				else if (!ack_slot)
				begin
					bit_cnt = bit_cnt + 1;
					if (!reading)
					begin
						rx_sh = {rx_sh[6:0], sda_o}; // msb first
						if (bit_cnt == 8)
							byte_o = rx_sh;
					end
				end
			end
			else if (scl_o === 1'b0 && active)
			begin
				if (ack_slot)
				begin
					ack_slot = 1'b0;
					sda_pull = 1'b0;
					bit_cnt  = 0;
					if (reading)
					begin
						tx_sh    = READ_BYTE;
						sda_pull = ~tx_sh[7];
					end
				end
				else if (mack_slot)
				begin
					mack_slot = 1'b0;
					bit_cnt   = 0;
					if (master_ack_o)
						active = 1'b0; // nack ends the read
					else
					begin
						tx_sh    = READ_BYTE;
						sda_pull = ~tx_sh[7];
					end
				end
				else if (bit_cnt == 8)
				begin
					if (reading)
					begin
						sda_pull  = 1'b0; // let the master ack
						mack_slot = 1'b1;
					end
					else if (addr_phase)
					begin
						addr_phase = 1'b0;
						if (rx_sh[7:1] == SLAVE_ADDR)
						begin
							reading  = rx_sh[0];
							ack_slot = 1'b1;
							sda_pull = 1'b1;
						end
						else
							active = 1'b0; // not us, no ack
					end
					else
					begin
						ack_slot = 1'b1;
						sda_pull = 1'b1;
					end
				end
				else if (reading && bit_cnt > 0)
				begin
					tx_sh    = {tx_sh[6:0], 1'b0};
					sda_pull = ~tx_sh[7];
				end
			end
		end
		else if (sda_o !== sda_prev && scl_o === 1'b1)
		begin
			if (sda_o === 1'b0)
			begin
				// start or repeated start
				active     = 1'b1;
				addr_phase = 1'b1;
				reading    = 1'b0;
				ack_slot   = 1'b0;
				mack_slot  = 1'b0;
				bit_cnt    = 0;
				sda_pull   = 1'b0;
			end
			else if (sda_o === 1'b1)
			begin
				active   = 1'b0; // stop
				sda_pull = 1'b0;
			end
		end
		scl_prev = scl_o;
		sda_prev = sda_o;
	end

endmodule

`default_nettype wire

//--- source/apb_i2c_master.sv
`timescale 1ns/10ps
`default_nettype none

module apb_i2c_master
(
	input  logic        clk,
	input  logic        rst,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [31:0] paddr_i,
	input  logic [31:0] pwdata_i,
	input  logic        scl_i,
	input  logic        sda_i,
	output logic        pready_o,
	output logic [31:0] prdata_o,
	output logic        scl_oen_o, // open drain, low pulls the line
	output logic        sda_oen_o,
	output logic        i2c_irq_o
);

	import i2c_proto_pkg::*;

	// register block to byte level
	logic      core_en;
	prescale_t prescale;
	byte_t     tx_byte;
	byte_t     rx_byte;
	logic      sta;
	logic      sto;
	logic      rd;
	logic      wr;
	logic      ack_bit;
	logic      done;
	logic      rx_ack;

	// byte level to bit level
	bit_cmd_t  bit_cmd;
	logic      bit_txd;
	logic      bit_ack;
	logic      bit_rxd;
	logic      phase_en;
	logic      ld;
	logic      shift;
	logic      cnt_done;

	apb_i2c_regs u_regs
	(
		.clk        (clk),
		.rst        (rst),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.addr_i     (paddr_i[7:2]), // byte address to word
		.wdata_i    (pwdata_i[7:0]),
		.done_i     (done),
		.rx_ack_i   (rx_ack),
		.rx_byte_i  (rx_byte),
		.pready_o   (pready_o),
		.rdata_o    (prdata_o),
		.core_en_o  (core_en),
		.i2c_irq_o  (i2c_irq_o),
		.prescale_o (prescale),
		.tx_byte_o  (tx_byte),
		.sta_o      (sta),
		.sto_o      (sto),
		.rd_o       (rd),
		.wr_o       (wr),
		.ack_o      (ack_bit)
	);

	i2c_byte_ctrl u_byte_ctrl
	(
		.clk        (clk),
		.rst        (rst),
		.sta_i      (sta),
		.sto_i      (sto),
		.rd_i       (rd),
		.wr_i       (wr),
		.ack_i      (ack_bit),
		.bit_ack_i  (bit_ack),
		.bit_rxd_i  (bit_rxd),
		.cnt_done_i (cnt_done),
		.sr_msb_i   (rx_byte[7]),
		.done_o     (done),
		.rx_ack_o   (rx_ack),
		.bit_cmd_o  (bit_cmd),
		.bit_txd_o  (bit_txd),
		.ld_o       (ld),
		.shift_o    (shift)
	);

	i2c_clk_div u_clk_div
	(
		.clk        (clk),
		.rst        (rst),
		.core_en_i  (core_en),
		.prescale_i (prescale),
		.phase_en_o (phase_en)
	);

	i2c_bit_seq u_bit_seq
	(
		.clk        (clk),
		.rst        (rst),
		.phase_en_i (phase_en),
		.bit_cmd_i  (bit_cmd),
		.txd_i      (bit_txd),
		.scl_i      (scl_i),
		.sda_i      (sda_i),
		.bit_ack_o  (bit_ack),
		.rxd_o      (bit_rxd),
		.scl_oen_o  (scl_oen_o),
		.sda_oen_o  (sda_oen_o)
	);

	// shared tx and rx byte
	i2c_shift_reg u_shift_reg
	(
		.clk         (clk),
		.rst         (rst),
		.ld_i        (ld),
		.shift_i     (shift),
		.load_byte_i (tx_byte),
		.rxd_i       (bit_rxd),
		.data_o      (rx_byte),
		.cnt_done_o  (cnt_done)
	);

endmodule

`default_nettype wire

//--- source/apb_i2c_regs.sv
`timescale 1ns/10ps
`default_nettype none

module apb_i2c_regs
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          psel_i,
	input  logic                          penable_i,
	input  logic                          pwrite_i,
	input  apb_i2c_regmap_pkg::reg_addr_t addr_i,     // word address
	input  i2c_proto_pkg::byte_t          wdata_i,
	input  logic                          done_i,     // byte command finished
	input  logic                          rx_ack_i,
	input  i2c_proto_pkg::byte_t          rx_byte_i,
	output logic                          pready_o,
	output logic [31:0]                   rdata_o,
	output logic                          core_en_o,
	output logic                          i2c_irq_o,  // flag gated by ien
	output i2c_proto_pkg::prescale_t      prescale_o,
	output i2c_proto_pkg::byte_t          tx_byte_o,
	output logic                          sta_o,
	output logic                          sto_o,
	output logic                          rd_o,
	output logic                          wr_o,
	output logic                          ack_o
);

	import i2c_proto_pkg::*;
	import apb_i2c_regmap_pkg::*;

	prescale_t prer;
	byte_t     ctr;
	byte_t     txr;
	byte_t     cr;
	byte_t     sr;
	byte_t     rd_byte;
	logic      wr_en;
	logic      rd_en;
	logic      rxack;
	logic      tip;
	logic      irq_flag; // sticky until iack

	assign wr_en    = psel_i & penable_i & pwrite_i; // access phase only
	assign rd_en    = psel_i & penable_i & ~pwrite_i;
	assign pready_o = 1'b1; // no wait states

	////////////////////
	// writable registers
	////////////////////
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			prer <= PRER_RESET;
			ctr  <= '0;
			txr  <= '0;
		end
		else if (wr_en)
		begin
			case (addr_i)
				ADDR_PRER_LO: prer[7:0]  <= wdata_i;
				ADDR_PRER_HI: prer[15:8] <= wdata_i;
				ADDR_CTR:     ctr        <= wdata_i;
				ADDR_TXR:     txr        <= wdata_i;
				default: ;
			endcase
		end
	end

	// command register, clears itself
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			cr <= '0;
		else if (wr_en && addr_i == ADDR_CR)
		begin
			if (ctr[CTR_EN])
				cr <= wdata_i; // dropped while core disabled
		end
		else
		begin
			if (done_i)
				cr[CR_STA:CR_WR] <= '0; // sta sto rd wr
			cr[2:1]     <= 2'b00; // reserved
			cr[CR_IACK] <= 1'b0;
		end
	end

	////////////////////
	// status and irq
	////////////////////
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rxack     <= 1'b0;
			tip       <= 1'b0;
			irq_flag  <= 1'b0;
			i2c_irq_o <= 1'b0;
		end
		else
		begin
			rxack     <= rx_ack_i;
			tip       <= rd_o | wr_o;
			irq_flag  <= (done_i | irq_flag) & ~cr[CR_IACK];
			i2c_irq_o <= irq_flag & ctr[CTR_IEN];
		end
	end

	always_comb
	begin
		sr           = '0; // busy and al read zero
		sr[SR_RXACK] = rxack;
		sr[SR_TIP]   = tip;
		sr[SR_IF]    = irq_flag;

		case (addr_i)
			ADDR_PRER_LO: rd_byte = prer[7:0];
			ADDR_PRER_HI: rd_byte = prer[15:8];
			ADDR_CTR:     rd_byte = ctr;
			ADDR_TXR:     rd_byte = txr;
			ADDR_RXR:     rd_byte = rx_byte_i;
			ADDR_CR:      rd_byte = cr;
			ADDR_SR:      rd_byte = sr;
			default:      rd_byte = '0;
		endcase
		rdata_o = rd_en ? {24'h0, rd_byte} : 32'h0; // zero outside a read
	end

	assign core_en_o  = ctr[CTR_EN];
	assign prescale_o = prer;
	assign tx_byte_o  = txr;
	assign sta_o      = cr[CR_STA];
	assign sto_o      = cr[CR_STO];
	assign rd_o       = cr[CR_RD];
	assign wr_o       = cr[CR_WR];
	assign ack_o      = cr[CR_ACK];

endmodule

`default_nettype wire

//--- source/i2c_byte_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_ctrl
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    sta_i,      // command bits from CR
	input  logic                    sto_i,
	input  logic                    rd_i,
	input  logic                    wr_i,
	input  logic                    ack_i,      // ack level to send after a read
	input  logic                    bit_ack_i,  // bit command finished
	input  logic                    bit_rxd_i,
	input  logic                    cnt_done_i, // 8th bit
	input  logic                    sr_msb_i,   // next bit to write
	output logic                    done_o,     // byte command complete
	output logic                    rx_ack_o,
	output i2c_proto_pkg::bit_cmd_t bit_cmd_o,
	output logic                    bit_txd_o,
	output logic                    ld_o,
	output logic                    shift_o
);

	import i2c_proto_pkg::*;

	byte_state_e state;
	byte_state_e state_nxt;
	logic        go;

	// bit command that belongs to a byte state
	function automatic bit_cmd_t cmd_for(input byte_state_e s, input logic rd);
		case (s)
			ST_START: return CMD_START;
			ST_WRITE: return CMD_WRITE;
			ST_READ:  return CMD_READ;
			ST_ACK:   return rd ? CMD_WRITE : CMD_READ; // opposite direction
			ST_STOP:  return CMD_STOP;
			default:  return CMD_NOP;
		endcase
	endfunction

	// new command, not the one just finished
	assign go = (rd_i | wr_i | sto_i) & ~done_o;

	////////////////////
	// next state
	////////////////////
	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (go)
					state_nxt = sta_i ? ST_START : rd_i ? ST_READ : wr_i ? ST_WRITE : ST_STOP;
			ST_START:
				if (bit_ack_i)
					state_nxt = rd_i ? ST_READ : ST_WRITE;
			ST_WRITE, ST_READ:
				if (bit_ack_i && cnt_done_i)
					state_nxt = ST_ACK; // 8 bits sent or taken
			ST_ACK:
				if (bit_ack_i)
					state_nxt = sto_i ? ST_STOP : ST_IDLE;
			ST_STOP:
				if (bit_ack_i)
					state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= ST_IDLE;
			bit_cmd_o <= CMD_NOP;
			bit_txd_o <= 1'b0;
			ld_o      <= 1'b0;
			shift_o   <= 1'b0;
			done_o    <= 1'b0;
			rx_ack_o  <= 1'b0;
		end
		else
		begin
			state     <= state_nxt;
			bit_cmd_o <= cmd_for(state_nxt, rd_i); // held as a level
			ld_o      <= ((state == ST_IDLE) & go) | ((state == ST_START) & bit_ack_i);
			shift_o   <= bit_ack_i & (((state == ST_WRITE) & ~cnt_done_i) | (state == ST_READ));
			done_o    <= bit_ack_i & (((state == ST_ACK) & ~sto_i) | (state == ST_STOP));

			if (state == ST_ACK)
				bit_txd_o <= bit_ack_i | ack_i; // sda released once ack bit is out
			else if (state == ST_READ && bit_ack_i)
				bit_txd_o <= ack_i; // master ack for the read byte
			else
				bit_txd_o <= sr_msb_i;

			if (state == ST_ACK && bit_ack_i)
				rx_ack_o <= bit_rxd_i; // slave ack on write, own ack on read
		end
	end

endmodule

`default_nettype wire

//--- source/i2c_bit_seq.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_seq
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    phase_en_i, // step one phase
	input  i2c_proto_pkg::bit_cmd_t bit_cmd_i,  // level, taken in idle
	input  logic                    txd_i,      // bit to write
	input  logic                    scl_i,
	input  logic                    sda_i,
	output logic                    bit_ack_o,  // command finished, one clk
	output logic                    rxd_o,      // sda at scl rise
	output logic                    scl_oen_o,  // active low, 0 pulls scl down
	output logic                    sda_oen_o   // active low, 0 pulls sda down
);

	import i2c_proto_pkg::*;

	logic [1:0] scl_q; // two flop sync
	logic [1:0] sda_q;
	logic       scl_d; // for rise detect
	bit_phase_e phase;
	bit_phase_e phase_nxt;
	logic       scl_nxt;
	logic       sda_nxt;
	logic       last_phase;

	////////////////////
	// bus line sync
	////////////////////
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			scl_q <= 2'b11; // released bus reads high
			sda_q <= 2'b11;
			scl_d <= 1'b1;
		end
		else
		begin
			scl_q <= {scl_q[0], scl_i};
			sda_q <= {sda_q[0], sda_i};
			scl_d <= scl_q[1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (scl_q[1] & ~scl_d)
			rxd_o <= sda_q[1]; // data valid while scl high
	end

	////////////////////
	// phase sequencer
	////////////////////
	always_comb
	begin
		case (phase)
			idle:
			begin
				case (bit_cmd_i)
					CMD_START: phase_nxt = start_a;
					CMD_STOP:  phase_nxt = stop_a;
					CMD_WRITE: phase_nxt = wr_a;
					CMD_READ:  phase_nxt = rd_a;
					default:   phase_nxt = idle; // nop
				endcase
			end
			start_a: phase_nxt = start_b;
			start_b: phase_nxt = start_c;
			start_c: phase_nxt = start_d;
			start_d: phase_nxt = start_e;
			stop_a:  phase_nxt = stop_b;
			stop_b:  phase_nxt = stop_c;
			stop_c:  phase_nxt = stop_d;
			rd_a:    phase_nxt = rd_b;
			rd_b:    phase_nxt = rd_c;
			rd_c:    phase_nxt = rd_d;
			wr_a:    phase_nxt = wr_b;
			wr_b:    phase_nxt = wr_c;
			wr_c:    phase_nxt = wr_d;
			default: phase_nxt = idle; // start_e, stop_d, rd_d, wr_d
		endcase

		// scl high in the middle of each bit
		case (phase)
			start_b, start_c, start_d, stop_b, stop_c, stop_d,
			rd_b, rd_c, wr_b, wr_c:                     scl_nxt = 1'b1;
			start_e, stop_a, rd_a, rd_d, wr_a, wr_d:   scl_nxt = 1'b0;
			default:                                    scl_nxt = scl_oen_o; // idle, start_a
		endcase

		case (phase)
			start_a, start_b, stop_d, rd_a, rd_b, rd_c, rd_d: sda_nxt = 1'b1; // released
			start_c, start_d, start_e, stop_a, stop_b, stop_c: sda_nxt = 1'b0;
			wr_a, wr_b, wr_c, wr_d:                            sda_nxt = txd_i;
			default:                                           sda_nxt = sda_oen_o; // hold
		endcase
	end

	assign last_phase = phase inside {start_e, stop_d, rd_d, wr_d};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			phase     <= idle;
			bit_ack_o <= 1'b0;
			scl_oen_o <= 1'b1;
			sda_oen_o <= 1'b1;
		end
		else
		begin
			bit_ack_o <= phase_en_i & last_phase; // after last phase edge
			if (phase_en_i)
			begin
				phase     <= phase_nxt;
				scl_oen_o <= scl_nxt;
				sda_oen_o <= sda_nxt;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/i2c_shift_reg.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_shift_reg
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ld_i,        // load tx byte and restart count
	input  logic                 shift_i,     // one bit done
	input  i2c_proto_pkg::byte_t load_byte_i,
	input  logic                 rxd_i,       // sampled sda
	output i2c_proto_pkg::byte_t data_o,      // msb goes out first
	output logic                 cnt_done_o
);

	import i2c_proto_pkg::*;

	logic [BIT_CNT_W-1:0] cnt; // bits left after the current one

	// tx and rx share the same register
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			data_o <= '0; // rxr reads zero out of reset
		else if (ld_i)
			data_o <= load_byte_i;
		else if (shift_i)
			data_o <= {data_o[BYTE_W-2:0], rxd_i}; // rx enters at lsb
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			cnt <= '0;
		else if (ld_i)
			cnt <= '1; // 7
		else if (shift_i)
			cnt <= cnt - 1'b1;
	end

	assign cnt_done_o = (cnt == '0); // last bit of the byte

endmodule

`default_nettype wire

//--- source/i2c_clk_div.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_clk_div
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     core_en_i,
	input  i2c_proto_pkg::prescale_t prescale_i, // phase period minus one
	output logic                     phase_en_o  // one clk wide, 4 per scl period
);

	import i2c_proto_pkg::*;

	prescale_t cnt; // down counter

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cnt        <= '0;
			phase_en_o <= 1'b1;
		end
		else if (cnt == '0 || !core_en_i)
		begin
			cnt        <= prescale_i; // reload, also while disabled
			phase_en_o <= 1'b1;
		end
		else
		begin
			cnt        <= cnt - 1'b1;
			phase_en_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/apb_i2c_regmap_pkg.sv
`default_nettype none

package apb_i2c_regmap_pkg;

	// word address, taken from paddr[7:2]
	typedef logic [5:0] reg_addr_t;

	////////////////////
	// register map
	////////////////////
	localparam reg_addr_t ADDR_PRER_LO = 6'd0; // prescale low byte
	localparam reg_addr_t ADDR_PRER_HI = 6'd1; // prescale high byte
	localparam reg_addr_t ADDR_CTR     = 6'd2; // control
	localparam reg_addr_t ADDR_TXR     = 6'd3; // transmit, write side
	localparam reg_addr_t ADDR_RXR     = 6'd4; // receive, read only
	localparam reg_addr_t ADDR_CR      = 6'd5; // command
	localparam reg_addr_t ADDR_SR      = 6'd6; // status, read only

	// command register bits
	localparam int CR_STA  = 7; // start before the byte
	localparam int CR_STO  = 6; // stop after the byte
	localparam int CR_RD   = 5;
	localparam int CR_WR   = 4;
	localparam int CR_ACK  = 3; // ack level sent on a read
	localparam int CR_IACK = 0; // clears the irq flag

	// control register bits
	localparam int CTR_EN  = 7;
	localparam int CTR_IEN = 6;

	// status register bits
	localparam int SR_RXACK = 7; // ack seen from slave
	localparam int SR_TIP   = 1; // transfer in progress
	localparam int SR_IF    = 0; // irq flag

	localparam logic [15:0] PRER_RESET = 16'hFFFF; // slowest scl out of reset

endpackage

`default_nettype wire

//--- source/i2c_proto_pkg.sv
`default_nettype none

package i2c_proto_pkg;

	////////////////////
	// widths
	////////////////////
	localparam int PRESCALE_W = 16; // prescale count
	localparam int BYTE_W     = 8;
	localparam int BIT_CNT_W  = 3;  // counts 7 down to 0

	typedef logic [PRESCALE_W-1:0] prescale_t;
	typedef logic [BYTE_W-1:0]     byte_t;
	typedef logic [3:0]            bit_cmd_t;

	////////////////////
	// bit commands, one-hot
	////////////////////
	localparam bit_cmd_t CMD_NOP   = 4'b0000;
	localparam bit_cmd_t CMD_START = 4'b0001;
	localparam bit_cmd_t CMD_STOP  = 4'b0010;
	localparam bit_cmd_t CMD_WRITE = 4'b0100;
	localparam bit_cmd_t CMD_READ  = 4'b1000;

	// four phases per bit, start has five
	typedef enum logic [4:0] {
		idle,
		start_a, start_b, start_c, start_d, start_e,
		stop_a, stop_b, stop_c, stop_d,
		rd_a, rd_b, rd_c, rd_d,
		wr_a, wr_b, wr_c, wr_d
	} bit_phase_e;

	// byte level sequencing
	typedef enum logic [2:0] {ST_IDLE, ST_START, ST_WRITE, ST_READ, ST_ACK, ST_STOP} byte_state_e;

endpackage

`default_nettype wire
